/* source/rvIsaPkg.sv */
package rvIsaPkg;

    // rv64 register width
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlenT;
    typedef logic [31:0]     instT;
    typedef logic [4:0]      regAddrT;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP      = 7'b0110011;
    localparam logic [6:0] OP32    = 7'b0111011;
    localparam logic [6:0] OPIMM   = 7'b0010011;
    localparam logic [6:0] OPIMM32 = 7'b0011011;
    localparam logic [6:0] LOAD    = 7'b0000011;
    localparam logic [6:0] JALR    = 7'b1100111;
    localparam logic [6:0] STORE   = 7'b0100011;
    localparam logic [6:0] BRANCH  = 7'b1100011;
    localparam logic [6:0] LUI     = 7'b0110111;
    localparam logic [6:0] AUIPC   = 7'b0010111;
    localparam logic [6:0] JAL     = 7'b1101111;
    localparam logic [6:0] SYSTEM  = 7'b1110011;

    // funct7 of the M extension
    localparam logic [6:0] F7MULDIV = 7'b0000001;

    // funct3 of the integer ops
    localparam logic [2:0] F3ADD  = 3'b000;
    localparam logic [2:0] F3SLL  = 3'b001;
    localparam logic [2:0] F3SLT  = 3'b010;
    localparam logic [2:0] F3SLTU = 3'b011;
    localparam logic [2:0] F3XOR  = 3'b100;
    localparam logic [2:0] F3SR   = 3'b101;
    localparam logic [2:0] F3OR   = 3'b110;
    localparam logic [2:0] F3AND  = 3'b111;

    // funct3 of mul and div
    localparam logic [2:0] F3MUL  = 3'b000;
    localparam logic [2:0] F3DIV  = 3'b100;
    localparam logic [2:0] F3DIVU = 3'b101;
    localparam logic [2:0] F3REM  = 3'b110;
    localparam logic [2:0] F3REMU = 3'b111;

    // branch conditions
    localparam logic [2:0] F3BEQ  = 3'b000;
    localparam logic [2:0] F3BNE  = 3'b001;
    localparam logic [2:0] F3BLT  = 3'b100;
    localparam logic [2:0] F3BGE  = 3'b101;
    localparam logic [2:0] F3BLTU = 3'b110;
    localparam logic [2:0] F3BGEU = 3'b111;

    // store widths
    localparam logic [2:0] F3SB = 3'b000;
    localparam logic [2:0] F3SH = 3'b001;
    localparam logic [2:0] F3SW = 3'b010;
    localparam logic [2:0] F3SD = 3'b011;

    // the one SYSTEM word that is decoded
    localparam instT EBREAKINST = 32'h0010_0073;

    typedef enum logic [2:0] {R, I, S, B, U, J, BAD} instFormatT;

endpackage

/* source/decodeStagePkg.sv */
package decodeStagePkg;

    import rvIsaPkg::*;

    typedef logic [4:0] aluOpT;
    typedef logic [7:0] storeMaskT;
    typedef logic [2:0] redirectKindT;

    // execute unit op codes
    localparam aluOpT ADD  = 5'd0;
    localparam aluOpT SUB  = 5'd1;
    localparam aluOpT XOR  = 5'd2;
    localparam aluOpT OR   = 5'd3;
    localparam aluOpT AND  = 5'd4;
    localparam aluOpT SLT  = 5'd5;
    localparam aluOpT SLTU = 5'd6;
    localparam aluOpT SLL  = 5'd7;
    localparam aluOpT SLLW = 5'd8;
    localparam aluOpT SRL  = 5'd9;
    localparam aluOpT SRA  = 5'd10;
    localparam aluOpT MUL  = 5'd11;
    // unsigned divide and remainder
    localparam aluOpT DIV  = 5'd12;
    localparam aluOpT DIVS = 5'd13;
    localparam aluOpT REM  = 5'd14;
    localparam aluOpT REMS = 5'd15;

    // one-hot bit positions in redirectKindT
    localparam int KINDJAL    = 0;
    localparam int KINDJALR   = 1;
    localparam int KINDBRANCH = 2;

    // link value added to pc
    localparam xlenT LINKSTEP = 64'd4;

    typedef struct packed {
        logic valid;
        xlenT pc;
        instT inst;
    } fetchBundleT;

    typedef struct packed {
        logic hit1;
        logic hit2;
        xlenT data;
    } bypassBundleT;

    typedef struct packed {
        logic      valid;
        xlenT      pc;
        instT      inst;
        aluOpT     aluOp;
        xlenT      opA;
        xlenT      opB;
        xlenT      imm;
        xlenT      rs2Value;
        regAddrT   rd;
        logic      wen;
        logic      loadFlag;
        logic      storeFlag;
        storeMaskT storeMask;
        logic [2:0] funct3;
        logic      word32;
        logic      jalrFlag;
        logic      ebreakFlag;
        logic      illegal;
    } issueBundleT;

    typedef struct packed {
        logic         valid;
        redirectKindT kind;
        xlenT         pc;
        xlenT         imm;
        xlenT         base;
    } redirectBundleT;

    typedef struct packed {
        logic    valid;
        logic    wen;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
    } scoreClaimT;

    typedef struct packed {
        instFormatT format;
        aluOpT      aluOp;
        xlenT       imm;
        regAddrT    rs1;
        regAddrT    rs2;
        regAddrT    rd;
        logic [2:0] funct3;
        logic       wen;
        logic       loadFlag;
        logic       storeFlag;
        logic       jalrFlag;
        logic       ebreakFlag;
        logic       word32;
        logic       illegal;
        // auipc takes pc as first operand, lui takes 0
        logic       upperPc;
        storeMaskT  storeMask;
        logic       signExt32;
        logic       zeroExt32;
        logic       extBoth;
        logic       shift5;
        logic       shift6;
        logic       immShift;
    } decodeInfoT;

endpackage

/* source/instDecoder.sv */
`timescale 1ns/10ps

module instDecoder import rvIsaPkg::*, decodeStagePkg::*; (
    input  fetchBundleT fetch,
    output regAddrT     regAddr1,
    output regAddrT     regAddr2,
    output decodeInfoT  info
);

    instT       inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       altBit;
    logic       isImmAlu;
    logic       isRegAlu;
    logic       word32;
    logic       mulDiv;
    logic       isShift;
    logic       ebreakFlag;
    instFormatT format;
    xlenT       imm;
    aluOpT      aluOp;
    storeMaskT  storeMask;

    // raw fields
    assign inst   = fetch.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    // sub and arithmetic shift select
    assign altBit = inst[30];

    // register file read addresses go out unconditionally
    assign regAddr1 = inst[19:15];
    assign regAddr2 = inst[24:20];

    // opcode groups
    assign isImmAlu   = (opcode == OPIMM) || (opcode == OPIMM32);
    assign isRegAlu   = (opcode == OP) || (opcode == OP32);
    assign word32     = (opcode == OPIMM32) || (opcode == OP32);
    assign mulDiv     = isRegAlu && (funct7 == F7MULDIV);
    assign isShift    = (isImmAlu || isRegAlu) && !mulDiv
                        && ((funct3 == F3SLL) || (funct3 == F3SR));
    assign ebreakFlag = (inst == EBREAKINST);

    // format classification
    always_comb begin
        case (opcode)
            OP, OP32:                       format = R;
            OPIMM, OPIMM32, LOAD, JALR:     format = I;
            STORE:                          format = S;
            BRANCH:                         format = B;
            LUI, AUIPC:                     format = U;
            JAL:                            format = J;
            // SYSTEM included, ebreak is told apart by its flag
            default:                        format = BAD;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        if (!fetch.valid) begin
            imm = '0;
        end else begin
            case (format)
                I:       imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
                S:       imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
                B:       imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                U:       imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
                J:       imm = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                default: imm = '0;
            endcase
        end
    end

    // alu op, I and R tables share funct3
    always_comb begin
        aluOp = ADD;
        if (mulDiv) begin
            case (funct3)
                F3MUL:   aluOp = MUL;
                F3DIV:   aluOp = DIVS;
                F3DIVU:  aluOp = DIV;
                F3REM:   aluOp = REMS;
                F3REMU:  aluOp = REM;
                default: aluOp = ADD;
            endcase
        end else if (isImmAlu || isRegAlu) begin
            case (funct3)
                // bit 30 means sub only in the register forms
                F3ADD:   aluOp = (isRegAlu && altBit) ? SUB : ADD;
                F3SLL:   aluOp = word32 ? SLLW : SLL;
                F3SLT:   aluOp = SLT;
                F3SLTU:  aluOp = SLTU;
                F3XOR:   aluOp = XOR;
                F3SR:    aluOp = altBit ? SRA : SRL;
                F3OR:    aluOp = OR;
                F3AND:   aluOp = AND;
                default: aluOp = ADD;
            endcase
        end
    end

    // byte enables for sb, sh, sw, sd
    always_comb begin
        storeMask = '0;
        if (opcode == STORE) begin
            case (funct3)
                F3SB:    storeMask = 8'h01;
                F3SH:    storeMask = 8'h03;
                F3SW:    storeMask = 8'h0f;
                F3SD:    storeMask = 8'hff;
                default: storeMask = '0;
            endcase
        end
    end

    always_comb begin
        info.format     = format;
        info.aluOp      = aluOp;
        info.imm        = imm;
        info.rs1        = inst[19:15];
        info.rs2        = inst[24:20];
        info.rd         = inst[11:7];
        info.funct3     = funct3;
        // stores, branches and unknown words write nothing
        info.wen        = (format != S) && (format != B) && (format != BAD);
        info.loadFlag   = (opcode == LOAD);
        info.storeFlag  = (opcode == STORE);
        info.jalrFlag   = (opcode == JALR);
        info.ebreakFlag = ebreakFlag;
        info.word32     = word32;
        info.illegal    = (format == BAD) && !ebreakFlag;
        info.upperPc    = (opcode == AUIPC);
        info.storeMask  = storeMask;
        // sraw/sraiw and divw/remw see a sign-extended low word
        info.signExt32  = word32 && ((isShift && funct3 == F3SR && altBit)
                          || (mulDiv && funct3[2] && !funct3[0]));
        // srlw/srliw and divuw/remuw see a zero-extended low word
        info.zeroExt32  = word32 && ((isShift && funct3 == F3SR && !altBit)
                          || (mulDiv && funct3[2] && funct3[0]));
        // W divide forms extend rs2 as well
        info.extBoth    = word32 && mulDiv && funct3[2];
        info.shift5     = word32 && isShift;
        info.shift6     = !word32 && isShift;
        info.immShift   = isImmAlu && isShift;
    end

endmodule

/* source/operandExecute.sv */
`timescale 1ns/10ps

module operandExecute import rvIsaPkg::*, decodeStagePkg::*; (
    input  fetchBundleT    fetch,
    input  decodeInfoT     info,
    input  xlenT           regData1,
    input  xlenT           regData2,
    input  logic           scoreBusy1,
    input  logic           scoreBusy2,
    input  bypassBundleT   bypass,
    input  logic           exReady,
    output issueBundleT    nextIssue,
    output redirectBundleT nextRedirect,
    output logic           stall,
    output logic           fetchReady,
    output scoreClaimT     scoreClaim
);

    xlenT src1;
    xlenT src2;
    xlenT shapedA;
    xlenT shapedB;
    xlenT opA;
    xlenT opB;
    logic eq;
    logic ltSigned;
    logic ltUnsigned;
    logic condMet;
    logic taken;
    logic accept;

    // low word extension for the W forms
    function automatic xlenT extend32(input xlenT value, input logic signExt,
                                      input logic zeroExt);
        xlenT result;
        result = value;
        if (signExt) begin
            result = {{(XLEN-32){value[31]}}, value[31:0]};
        end else if (zeroExt) begin
            result = {{(XLEN-32){1'b0}}, value[31:0]};
        end
        return result;
    endfunction

    // keep 5 or 6 bits of a shift amount
    function automatic xlenT maskShift(input xlenT value, input logic narrow,
                                       input logic wide);
        xlenT result;
        result = value;
        if (narrow) begin
            result = xlenT'(value[4:0]);
        end else if (wide) begin
            result = xlenT'(value[5:0]);
        end
        return result;
    endfunction

    // bypass only when the register is really in flight,
    // so a pending write to x0 never leaks in
    assign src1 = (scoreBusy1 && bypass.hit1) ? bypass.data : regData1;
    assign src2 = (scoreBusy2 && bypass.hit2) ? bypass.data : regData2;
    assign stall = (scoreBusy1 && !bypass.hit1) || (scoreBusy2 && !bypass.hit2);

    // handshake, ebreak parks the fetch side
    assign fetchReady = exReady && !stall && !(fetch.valid && info.ebreakFlag);
    assign accept     = fetch.valid && fetchReady;

    assign scoreClaim.valid = fetch.valid && !info.ebreakFlag;
    assign scoreClaim.wen   = accept && info.wen;
    assign scoreClaim.rs1   = info.rs1;
    assign scoreClaim.rs2   = info.rs2;
    assign scoreClaim.rd    = info.rd;

    // branch compare
    assign eq         = (src1 == src2);
    assign ltSigned   = ($signed(src1) < $signed(src2));
    assign ltUnsigned = (src1 < src2);

    always_comb begin
        case (info.funct3)
            F3BEQ:   condMet = eq;
            F3BNE:   condMet = !eq;
            F3BLT:   condMet = ltSigned;
            F3BGE:   condMet = !ltSigned;
            F3BLTU:  condMet = ltUnsigned;
            F3BGEU:  condMet = !ltUnsigned;
            default: condMet = 1'b0;
        endcase
    end

    assign taken = (info.format == B) && condMet;

    assign shapedA = extend32(src1, info.signExt32, info.zeroExt32);
    assign shapedB = extend32(src2, info.signExt32, info.zeroExt32);

    // alu operands by format
    always_comb begin
        case (info.format)
            I: begin
                if (info.jalrFlag) begin
                    opA = fetch.pc;
                    opB = LINKSTEP;
                end else begin
                    opA = shapedA;
                    opB = info.immShift ? maskShift(info.imm, info.shift5, info.shift6)
                                        : info.imm;
                end
            end
            R: begin
                opA = shapedA;
                opB = info.extBoth ? shapedB : maskShift(src2, info.shift5, info.shift6);
            end
            S: begin
                opA = src1;
                opB = info.imm;
            end
            U: begin
                opA = info.upperPc ? fetch.pc : '0;
                opB = info.imm;
            end
            J: begin
                opA = fetch.pc;
                opB = LINKSTEP;
            end
            // branches resolve here, nothing for the alu
            default: begin
                opA = '0;
                opB = '0;
            end
        endcase
    end

    always_comb begin
        nextIssue.valid      = fetch.valid;
        nextIssue.pc         = fetch.pc;
        nextIssue.inst       = fetch.inst;
        nextIssue.aluOp      = info.aluOp;
        nextIssue.opA        = opA;
        nextIssue.opB        = opB;
        nextIssue.imm        = info.imm;
        nextIssue.rs2Value   = src2;
        nextIssue.rd         = info.rd;
        nextIssue.wen        = info.wen;
        nextIssue.loadFlag   = info.loadFlag;
        nextIssue.storeFlag  = info.storeFlag;
        nextIssue.storeMask  = info.storeMask;
        nextIssue.funct3     = info.funct3;
        nextIssue.word32     = info.word32;
        nextIssue.jalrFlag   = info.jalrFlag;
        nextIssue.ebreakFlag = info.ebreakFlag;
        nextIssue.illegal    = info.illegal;
    end

    // redirect target is base + imm, computed downstream
    always_comb begin
        nextRedirect.valid              = fetch.valid;
        nextRedirect.kind               = '0;
        nextRedirect.kind[KINDJAL]      = (info.format == J);
        nextRedirect.kind[KINDJALR]     = info.jalrFlag;
        nextRedirect.kind[KINDBRANCH]   = taken;
        nextRedirect.pc                 = fetch.pc;
        nextRedirect.imm                = info.imm;
        nextRedirect.base               = info.jalrFlag ? src1 : fetch.pc;
    end

endmodule

/* source/issueRegister.sv */
`timescale 1ns/10ps

module issueRegister import decodeStagePkg::*; (
    input  logic           clock,
    input  logic           rst,
    input  logic           exReady,
    input  logic           stall,
    input  issueBundleT    nextIssue,
    input  redirectBundleT nextRedirect,
    output issueBundleT    issue,
    output redirectBundleT redirect
);

    // ID/EX boundary, loads only when execute takes the previous item
    always_ff @(posedge clock) begin
        if (rst) begin
            issue.valid    <= 1'b0;
            redirect.valid <= 1'b0;
        end else if (exReady) begin
            issue          <= nextIssue;
            redirect       <= nextRedirect;
            // a stalled slot turns into a bubble
            issue.valid    <= nextIssue.valid && !stall;
            redirect.valid <= nextRedirect.valid && !stall;
        end
    end

endmodule

/* source/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage import rvIsaPkg::*, decodeStagePkg::*; (
    input  logic           clock,
    input  logic           rst,
    input  fetchBundleT    fetch,
    input  xlenT           regData1,
    input  xlenT           regData2,
    input  logic           scoreBusy1,
    input  logic           scoreBusy2,
    input  bypassBundleT   bypass,
    input  logic           exReady,
    output regAddrT        regAddr1,
    output regAddrT        regAddr2,
    output logic           fetchReady,
    output scoreClaimT     scoreClaim,
    output issueBundleT    issue,
    output redirectBundleT redirect
);

    decodeInfoT     info;
    issueBundleT    nextIssue;
    redirectBundleT nextRedirect;
    logic           stall;

    // pure field decode
    instDecoder i_instDecoder (
        .fetch    (fetch),
        .regAddr1 (regAddr1),
        .regAddr2 (regAddr2),
        .info     (info)
    );

    // sources, hazards, branch and operands, same cycle
    operandExecute i_operandExecute (
        .fetch        (fetch),
        .info         (info),
        .regData1     (regData1),
        .regData2     (regData2),
        .scoreBusy1   (scoreBusy1),
        .scoreBusy2   (scoreBusy2),
        .bypass       (bypass),
        .exReady      (exReady),
        .nextIssue    (nextIssue),
        .nextRedirect (nextRedirect),
        .stall        (stall),
        .fetchReady   (fetchReady),
        .scoreClaim   (scoreClaim)
    );

    // one cycle to execute
    issueRegister i_issueRegister (
        .clock        (clock),
        .rst          (rst),
        .exReady      (exReady),
        .stall        (stall),
        .nextIssue    (nextIssue),
        .nextRedirect (nextRedirect),
        .issue        (issue),
        .redirect     (redirect)
    );

endmodule

/* bench/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
    output logic clock,
    output logic rst
);

    // half of the 4 ns period
    localparam int HALFPERIOD = 2;
    localparam int RESETCYCLES = 3;

    initial begin
        clock = 1'b0;
        forever begin
            #(HALFPERIOD) clock = ~clock;
        end
    end

    // reset held over the first three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESETCYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule

/* bench/decodeVectors.svh */
// columns: inst, fixedRegs, reg1, reg2, busy{1,2}, hit{1,2}, exReady,
//   expReady, expClaim, expValid, hold, aluOp, selA, selB, imm, mask, illegal, kind

// operand selectors, resolved against the row's sources in the testbench
localparam logic [3:0] SELZERO  = 4'd0;
localparam logic [3:0] SELPC    = 4'd1;
localparam logic [3:0] SELFOUR  = 4'd2;
localparam logic [3:0] SELRS1   = 4'd3;
localparam logic [3:0] SELRS1ZX = 4'd4;
localparam logic [3:0] SELRS2   = 4'd5;
localparam logic [3:0] SELRS2ZX = 4'd6;
localparam logic [3:0] SELRS2M5 = 4'd7;
localparam logic [3:0] SELIMM   = 4'd8;
localparam logic [3:0] SELIMMM5 = 4'd9;
localparam logic [3:0] SELIMMM6 = 4'd10;

localparam int NUMROWS = 32;

typedef struct packed {
    instT         inst;
    logic         fixedRegs;
    xlenT         reg1;
    xlenT         reg2;
    logic [1:0]   busy;
    logic [1:0]   hit;
    logic         exReady;
    logic         expReady;
    logic         expClaim;
    logic         expValid;
    logic         hold;
    aluOpT        aluOp;
    logic [3:0]   selA;
    logic [3:0]   selB;
    xlenT         imm;
    storeMaskT    mask;
    logic         illegal;
    redirectKindT kind;
} vecT;

vecT vectors [NUMROWS];
int  fillIndex = 0;

task automatic addVector(input vecT v);
    vectors[fillIndex] = v;
    fillIndex++;
endtask

task automatic fillVectors();
    // alu decode: addi, xori, srai, srliw, sub, mulw, remuw, sllw, unknown
    addVector('{32'hffb08193, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'hffff_ffff_ffff_fffb, 8'h00, 0, 3'b000});
    addVector('{32'h0f00c193, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, XOR, SELRS1, SELIMM,
                64'h0f0, 8'h00, 0, 3'b000});
    addVector('{32'h4230d193, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, SRA, SELRS1, SELIMMM6,
                64'h423, 8'h00, 0, 3'b000});
    addVector('{32'h0070d19b, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, SRL, SELRS1ZX, SELIMMM5,
                64'h7, 8'h00, 0, 3'b000});
    addVector('{32'h402081b3, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, SUB, SELRS1, SELRS2,
                64'h0, 8'h00, 0, 3'b000});
    addVector('{32'h022081bb, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, MUL, SELRS1, SELRS2,
                64'h0, 8'h00, 0, 3'b000});
    addVector('{32'h0220f1bb, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, REM, SELRS1ZX, SELRS2ZX,
                64'h0, 8'h00, 0, 3'b000});
    addVector('{32'h002091bb, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, SLLW, SELRS1, SELRS2M5,
                64'h0, 8'h00, 0, 3'b000});
    addVector('{32'h0000007f, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELZERO, SELZERO,
                64'h0, 8'h00, 1, 3'b000});
    // memory and upper immediates: ld, sb, sh, sw, sd, lui, auipc
    addVector('{32'h0080b183, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'h8, 8'h00, 0, 3'b000});
    addVector('{32'h00208223, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'h4, 8'h01, 0, 3'b000});
    addVector('{32'h00209223, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'h4, 8'h03, 0, 3'b000});
    addVector('{32'h0020a223, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'h4, 8'h0f, 0, 3'b000});
    addVector('{32'h0020b223, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'h4, 8'hff, 0, 3'b000});
    addVector('{32'h123451b7, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELZERO, SELIMM,
                64'h1234_5000, 8'h00, 0, 3'b000});
    addVector('{32'h80000197, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELPC, SELIMM,
                64'hffff_ffff_8000_0000, 8'h00, 0, 3'b000});
    // jumps
    addVector('{32'h010001ef, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELPC, SELFOUR,
                64'h10, 8'h00, 0, 3'b001});
    addVector('{32'h00c081e7, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELPC, SELFOUR,
                64'hc, 8'h00, 0, 3'b010});
    // branches with rs1 = -16 and rs2 = 5
    addVector('{32'h00208463, 1, 64'hffff_ffff_ffff_fff0, 64'h5, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b000});
    addVector('{32'h00209463, 1, 64'hffff_ffff_ffff_fff0, 64'h5, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b100});
    addVector('{32'h0020c463, 1, 64'hffff_ffff_ffff_fff0, 64'h5, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b100});
    addVector('{32'h0020d463, 1, 64'hffff_ffff_ffff_fff0, 64'h5, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b000});
    addVector('{32'h0020e463, 1, 64'hffff_ffff_ffff_fff0, 64'h5, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b000});
    addVector('{32'h0020f463, 1, 64'hffff_ffff_ffff_fff0, 64'h5, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b100});
    addVector('{32'h00208463, 1, 64'h77, 64'h77, 2'b00, 2'b00, 1, 1, 1, 1, 0,
                ADD, SELZERO, SELZERO, 64'h8, 8'h00, 0, 3'b100});
    // hazards: busy without hit, bypassed rs2, bypassed jalr base, ebreak
    addVector('{32'hffb08193, 0, '0, '0, 2'b10, 2'b00, 1, 0, 1, 0, 0, ADD, SELRS1, SELIMM,
                64'hffff_ffff_ffff_fffb, 8'h00, 0, 3'b000});
    addVector('{32'h402081b3, 0, '0, '0, 2'b01, 2'b01, 1, 1, 1, 1, 0, SUB, SELRS1, SELRS2,
                64'h0, 8'h00, 0, 3'b000});
    addVector('{32'h00c081e7, 0, '0, '0, 2'b10, 2'b10, 1, 1, 1, 1, 0, ADD, SELPC, SELFOUR,
                64'hc, 8'h00, 0, 3'b010});
    addVector('{32'h00100073, 0, '0, '0, 2'b00, 2'b00, 1, 0, 0, 1, 0, ADD, SELZERO, SELZERO,
                64'h0, 8'h00, 0, 3'b000});
    // back-pressure: load, then a held cycle, then a normal issue
    addVector('{32'h0080b183, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, ADD, SELRS1, SELIMM,
                64'h8, 8'h00, 0, 3'b000});
    addVector('{32'h0f00c193, 0, '0, '0, 2'b00, 2'b00, 0, 0, 1, 0, 1, XOR, SELRS1, SELIMM,
                64'h0f0, 8'h00, 0, 3'b000});
    addVector('{32'h0f00c193, 0, '0, '0, 2'b00, 2'b00, 1, 1, 1, 1, 0, XOR, SELRS1, SELIMM,
                64'h0f0, 8'h00, 0, 3'b000});
endtask

/* bench/decodeStageTb.sv */
`timescale 1ns/10ps

module decodeStageTb import rvIsaPkg::*, decodeStagePkg::*; ();

    localparam int CLOCKPERIOD = 4;
    localparam int RESETCYCLES = 3;

    logic           clock;
    logic           rst;
    fetchBundleT    fetch;
    xlenT           regData1;
    xlenT           regData2;
    logic           scoreBusy1;
    logic           scoreBusy2;
    bypassBundleT   bypass;
    logic           exReady;
    regAddrT        regAddr1;
    regAddrT        regAddr2;
    logic           fetchReady;
    scoreClaimT     scoreClaim;
    issueBundleT    issue;
    redirectBundleT redirect;
    int             seed;

    `include "decodeVectors.svh"

    // three cycles per row is ample for a one-cycle stage
    localparam int WATCHDOGCYCLES = NUMROWS * 3 + RESETCYCLES;

    clockGen i_clockGen (
        .clock (clock),
        .rst   (rst)
    );

    decodeStage i_decodeStage (
        .clock      (clock),
        .rst        (rst),
        .fetch      (fetch),
        .regData1   (regData1),
        .regData2   (regData2),
        .scoreBusy1 (scoreBusy1),
        .scoreBusy2 (scoreBusy2),
        .bypass     (bypass),
        .exReady    (exReady),
        .regAddr1   (regAddr1),
        .regAddr2   (regAddr2),
        .fetchReady (fetchReady),
        .scoreClaim (scoreClaim),
        .issue      (issue),
        .redirect   (redirect)
    );

    task automatic stopOnFailure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input xlenT got, input xlenT exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            stopOnFailure();
        end
    endtask

    // expected operand from the shaping rules
    function automatic xlenT pickOperand(input logic [3:0] sel, input xlenT pc,
                                         input xlenT src1, input xlenT src2, input xlenT imm);
        xlenT result;
        case (sel)
            SELPC:    result = pc;
            SELFOUR:  result = 64'd4;
            SELRS1:   result = src1;
            SELRS1ZX: result = {32'b0, src1[31:0]};
            SELRS2:   result = src2;
            SELRS2ZX: result = {32'b0, src2[31:0]};
            SELRS2M5: result = {59'b0, src2[4:0]};
            SELIMM:   result = imm;
            SELIMMM5: result = {59'b0, imm[4:0]};
            SELIMMM6: result = {58'b0, imm[5:0]};
            default:  result = '0;
        endcase
        return result;
    endfunction

    // drive one row on the falling edge and check both sides of the register
    task automatic runVector(input int index);
        vecT            v;
        xlenT           pc;
        xlenT           r1;
        xlenT           r2;
        xlenT           byp;
        xlenT           src1;
        xlenT           src2;
        xlenT           expBase;
        logic           expWen;
        issueBundleT    heldIssue;
        redirectBundleT heldRedirect;
        v  = vectors[index];
        pc = 64'h8000_0000 + 64'(index * 4);
        if (v.fixedRegs) begin
            r1 = v.reg1;
            r2 = v.reg2;
        end else begin
            r1 = {$random(seed), $random(seed)};
            r2 = {$random(seed), $random(seed)};
        end
        byp  = {$random(seed), $random(seed)};
        src1 = (v.busy[1] && v.hit[1]) ? byp : r1;
        src2 = (v.busy[0] && v.hit[0]) ? byp : r2;
        // jalr jumps from rs1 and everything else from pc
        expBase = (v.inst[6:0] == JALR) ? src1 : pc;
        // stores, branches and unknown words have no destination
        expWen = v.expReady && (v.inst[6:0] != STORE) && (v.inst[6:0] != BRANCH)
                 && !v.illegal;
        heldIssue    = issue;
        heldRedirect = redirect;

        fetch.valid = 1'b1;
        fetch.pc    = pc;
        fetch.inst  = v.inst;
        regData1    = r1;
        regData2    = r2;
        scoreBusy1  = v.busy[1];
        scoreBusy2  = v.busy[0];
        bypass.hit1 = v.hit[1];
        bypass.hit2 = v.hit[0];
        bypass.data = byp;
        exReady     = v.exReady;

        // combinational side checked before the rising edge
        #1;
        checkValue("fetchReady", 64'(fetchReady), 64'(v.expReady));
        checkValue("scoreClaim.valid", 64'(scoreClaim.valid), 64'(v.expClaim));
        checkValue("scoreClaim.wen", 64'(scoreClaim.wen), 64'(expWen));
        // rs1 and rs2 fields of the instruction word
        checkValue("regAddr1", 64'(regAddr1), 64'(v.inst[19:15]));
        checkValue("regAddr2", 64'(regAddr2), 64'(v.inst[24:20]));

        @(posedge clock);
        #1;
        if (v.hold) begin
            assert (issue === heldIssue) else begin
                $display("ERR issue got 0x%h expected 0x%h", issue, heldIssue);
                stopOnFailure();
            end
            assert (redirect === heldRedirect) else begin
                $display("ERR redirect got 0x%h expected 0x%h", redirect, heldRedirect);
                stopOnFailure();
            end
        end else if (v.expValid) begin
            checkValue("issue.valid", 64'(issue.valid), 64'd1);
            checkValue("redirect.valid", 64'(redirect.valid), 64'd1);
            checkValue("issue.aluOp", 64'(issue.aluOp), 64'(v.aluOp));
            checkValue("issue.opA", issue.opA, pickOperand(v.selA, pc, src1, src2, v.imm));
            checkValue("issue.opB", issue.opB, pickOperand(v.selB, pc, src1, src2, v.imm));
            checkValue("issue.imm", issue.imm, v.imm);
            checkValue("issue.storeMask", 64'(issue.storeMask), 64'(v.mask));
            checkValue("issue.illegal", 64'(issue.illegal), 64'(v.illegal));
            checkValue("redirect.kind", 64'(redirect.kind), 64'(v.kind));
            checkValue("redirect.base", redirect.base, expBase);
        end else begin
            // stalled slot becomes a bubble
            checkValue("issue.valid", 64'(issue.valid), 64'd0);
            checkValue("redirect.valid", 64'(redirect.valid), 64'd0);
        end
        @(negedge clock);
    endtask

    initial begin
        seed       = 32'h530c_2c6a;
        fetch      = '0;
        regData1   = '0;
        regData2   = '0;
        scoreBusy1 = 1'b0;
        scoreBusy2 = 1'b0;
        bypass     = '0;
        exReady    = 1'b1;
        fillVectors();

        // whole reset pulse, it drops on a falling edge
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        #1;
        checkValue("issue.valid", 64'(issue.valid), 64'd0);
        checkValue("redirect.valid", 64'(redirect.valid), 64'd0);
        @(negedge clock);

        for (int row = 0; row < NUMROWS; row++) begin
            runVector(row);
        end

        fetch.valid = 1'b0;
        $display("Regression passed");
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        #(WATCHDOGCYCLES * CLOCKPERIOD);
        $display("watchdog expired before all vectors were applied");
        stopOnFailure();
    end

endmodule

/* flist.f */
+incdir+bench
source/rvIsaPkg.sv
source/decodeStagePkg.sv
source/instDecoder.sv
source/operandExecute.sv
source/issueRegister.sv
source/decodeStage.sv
bench/clockGen.sv
bench/decodeStageTb.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStageTb
SEED      ?= 1
BUILD     ?= obj_dir
FLIST     ?= flist.f
PASSTEXT  ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES) bench/decodeVectors.svh
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

# pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(BUILD)
